// File: voters.svh
`ifndef VOTERS_SVH
`define VOTERS_SVH

// Bitwise majority of three words
`define MAJ3(a, b, c) (((a) & (b)) | ((a) & (c)) | ((b) & (c)))

// Three replicas reduced to one voted word
`define VOTE3TO1(in_w, out_w) \
    out_w = `MAJ3(in_w[0], in_w[1], in_w[2])

// Three replicas voted back into three copies
`define VOTE3TO3(in_w, out_w) \
    out_w[0] = `MAJ3(in_w[0], in_w[1], in_w[2]); \
    out_w[1] = `MAJ3(in_w[0], in_w[1], in_w[2]); \
    out_w[2] = `MAJ3(in_w[0], in_w[1], in_w[2])

// Enumerations are voted by equality so the result is always a legal state
`define VOTE3TO3ENUM(in_s, out_s) \
    out_s[0] = (in_s[0] == in_s[1]) ? in_s[0] : in_s[2]; \
    out_s[1] = (in_s[0] == in_s[1]) ? in_s[0] : in_s[2]; \
    out_s[2] = (in_s[0] == in_s[1]) ? in_s[0] : in_s[2]

`endif

// File: tdmr_pkg.sv
package tdmr_pkg;

    // Width of one multiply operand
    localparam int OP_W = 16;

    // Input word holds operand a above operand b, and the product is as wide
    localparam int DATA_W = 2 * OP_W;

    // Two counter bits with an even parity bit in the top position
    localparam int ID_W = 3;

    // States of the replicating front block
    typedef enum logic [1:0] {
        STORE_AND_SEND,
        SEND,
        REPLICATE
    } dmr_state_t;

    // States of the pairing and compare block
    typedef enum logic [1:0] {
        WAIT_FIRST,
        WAIT_SECOND,
        EMIT
    } end_state_t;

endpackage

// File: tdmr_stream_if.sv
`timescale 1ns/10ps

interface tdmr_stream_if #(
    parameter int DATA_W = 32,
    parameter int ID_W   = 3
);

    logic [DATA_W-1:0] data;
    logic [ID_W-1:0]   id;
    logic              valid;
    logic              ready;

    // Producer drives payload and valid, consumer answers with ready
    modport source (output data, id, valid, input ready);
    modport sink (input data, id, valid, output ready);

endinterface

// File: time_dmr_start.sv
`timescale 1ns/10ps

`include "voters.svh"

module time_dmr_start #(
    parameter int DATA_W = 32,
    parameter int ID_W   = 3
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              enable_i,
    input  logic [DATA_W-1:0] in_data_i,
    input  logic              in_valid_i,
    output logic              in_ready_o,
    tdmr_stream_if.source     rep
);

    import tdmr_pkg::*;

    dmr_state_t state_v [3];
    dmr_state_t state_d [3];
    dmr_state_t state_q [3];

    logic [2:0][ID_W-1:0] id_v, id_d, id_q, id_next;
    logic [2:0][ID_W-2:0] cnt_next;
    logic [DATA_W-1:0]    data_q;
    logic                 store_en;

    // Each replica computes its own next state and next ID
    always_comb begin : next_state_logic
        for (int r = 0; r < 3; r++) begin
            state_v[r]  = state_q[r];
            id_v[r]     = id_q[r];
            cnt_next[r] = id_q[r][ID_W-2:0] + 1'b1;
            // Even parity over the whole ID
            id_next[r]  = {^cnt_next[r], cnt_next[r]};

            case (state_q[r])
                STORE_AND_SEND: begin
                    if (in_valid_i) begin
                        id_v[r] = id_next[r];
                        if (!rep.ready) begin
                            state_v[r] = SEND;
                        end else if (enable_i) begin
                            state_v[r] = REPLICATE;
                        end
                    end
                end
                SEND: begin
                    if (rep.ready) begin
                        state_v[r] = enable_i ? REPLICATE : STORE_AND_SEND;
                    end
                end
                REPLICATE: begin
                    if (rep.ready) begin
                        state_v[r] = STORE_AND_SEND;
                    end
                end
                default: begin
                    state_v[r] = STORE_AND_SEND;
                end
            endcase
        end
    end

    always_comb begin : voting_logic
        `VOTE3TO3ENUM(state_v, state_d);
        `VOTE3TO3(id_v, id_d);
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin : state_regs
        if (!rst_n_i) begin
            state_q <= '{default: STORE_AND_SEND};
            id_q    <= '0;
        end else begin
            state_q <= state_d;
            id_q    <= id_d;
        end
    end

    // Word is kept for the second pass and for a stalled first pass
    assign store_en = (state_q[0] == STORE_AND_SEND) && in_valid_i;

    always_ff @(posedge clk_i) begin : data_reg
        if (store_en) begin
            data_q <= in_data_i;
        end
    end

    // First copy passes straight through, replays come from the store
    always_comb begin : output_logic
        if (state_q[0] == STORE_AND_SEND) begin
            rep.valid  = in_valid_i;
            rep.data   = in_data_i;
            in_ready_o = 1'b1;
        end else begin
            rep.valid  = 1'b1;
            rep.data   = data_q;
            in_ready_o = 1'b0;
        end
        `VOTE3TO1(id_v, rep.id);
    end

endmodule

// File: mul_pipe.sv
`timescale 1ns/10ps

module mul_pipe #(
    parameter int DATA_W = 32,
    parameter int ID_W   = 3
) (
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  logic          upset_i,
    tdmr_stream_if.sink   rep,
    tdmr_stream_if.source prod
);

    localparam int HALF_W = DATA_W / 2;

    logic              advance;
    logic [HALF_W-1:0] op_a;
    logic [HALF_W-1:0] op_b;
    logic [DATA_W-1:0] product;
    logic [DATA_W-1:0] flip_mask;

    logic              s1_valid_q;
    logic              s2_valid_q;
    logic [DATA_W-1:0] s1_prod_q;
    logic [DATA_W-1:0] s2_prod_q;
    logic [ID_W-1:0]   s1_id_q;
    logic [ID_W-1:0]   s2_id_q;

    // Whole pipe freezes only when the output is held back
    assign advance   = !s2_valid_q || prod.ready;
    assign rep.ready = advance;

    assign op_a    = rep.data[DATA_W-1:HALF_W];
    assign op_b    = rep.data[HALF_W-1:0];
    assign product = DATA_W'(op_a) * DATA_W'(op_b);

    // Single-event upset on the LSB of the stage 1 result
    assign flip_mask = {{(DATA_W-1){1'b0}}, upset_i};

    always_ff @(posedge clk_i or negedge rst_n_i) begin : valid_regs
        if (!rst_n_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else if (advance) begin
            s1_valid_q <= rep.valid;
            s2_valid_q <= s1_valid_q;
        end
    end

    always_ff @(posedge clk_i) begin : payload_regs
        if (advance) begin
            s1_prod_q <= product ^ flip_mask;
            s1_id_q   <= rep.id;
            s2_prod_q <= s1_prod_q;
            s2_id_q   <= s1_id_q;
        end
    end

    assign prod.valid = s2_valid_q;
    assign prod.data  = s2_prod_q;
    assign prod.id    = s2_id_q;

endmodule

// File: time_dmr_end.sv
`timescale 1ns/10ps

`include "voters.svh"

module time_dmr_end #(
    parameter int DATA_W = 32,
    parameter int ID_W   = 3
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              enable_i,
    tdmr_stream_if.sink       prod,
    output logic [DATA_W-1:0] out_data_o,
    output logic              out_fault_o,
    output logic              out_valid_o,
    input  logic              out_ready_i
);

    import tdmr_pkg::*;

    end_state_t state_v [3];
    end_state_t state_d [3];
    end_state_t state_q [3];

    logic [DATA_W-1:0] first_data_q;
    logic [ID_W-1:0]   first_id_q;
    logic [DATA_W-1:0] res_data_q;
    logic              fault_q;
    logic              take_first;
    logic              take_result;
    logic              mismatch;

    always_comb begin : next_state_logic
        for (int r = 0; r < 3; r++) begin
            state_v[r] = state_q[r];
            case (state_q[r])
                WAIT_FIRST: begin
                    if (prod.valid) begin
                        state_v[r] = enable_i ? WAIT_SECOND : EMIT;
                    end
                end
                WAIT_SECOND: begin
                    if (prod.valid) begin
                        state_v[r] = EMIT;
                    end
                end
                EMIT: begin
                    if (out_ready_i) begin
                        state_v[r] = WAIT_FIRST;
                    end
                end
                default: begin
                    state_v[r] = WAIT_FIRST;
                end
            endcase
        end
    end

    always_comb begin : voting_logic
        `VOTE3TO3ENUM(state_v, state_d);
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin : state_regs
        if (!rst_n_i) begin
            state_q <= '{default: WAIT_FIRST};
        end else begin
            state_q <= state_d;
        end
    end

    assign prod.ready  = (state_q[0] != EMIT);
    assign take_first  = prod.valid && (state_q[0] == WAIT_FIRST) && enable_i;
    assign take_result = prod.valid && ((state_q[0] == WAIT_SECOND) ||
                         ((state_q[0] == WAIT_FIRST) && !enable_i));

    // Any difference in data or ID, or a bad parity on either copy
    assign mismatch = (first_data_q != prod.data) || (first_id_q != prod.id) ||
                      (^prod.id) || (^first_id_q);

    always_ff @(posedge clk_i) begin : data_regs
        if (take_first) begin
            first_data_q <= prod.data;
            first_id_q   <= prod.id;
        end
        if (take_result) begin
            res_data_q <= prod.data;
        end
    end

    // Unchecked results leave with the flag low
    always_ff @(posedge clk_i or negedge rst_n_i) begin : fault_reg
        if (!rst_n_i) begin
            fault_q <= 1'b0;
        end else if (take_result) begin
            fault_q <= (state_q[0] == WAIT_SECOND) && mismatch;
        end
    end

    assign out_valid_o = (state_q[0] == EMIT);
    assign out_data_o  = res_data_q;
    assign out_fault_o = fault_q;

endmodule

// File: tdmr_top.sv
`timescale 1ns/10ps

module tdmr_top #(
    parameter int DATA_W = tdmr_pkg::DATA_W,
    parameter int ID_W   = tdmr_pkg::ID_W
) (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              enable_i,
    input  logic              upset_i,
    input  logic [DATA_W-1:0] in_data_i,
    input  logic              in_valid_i,
    output logic              in_ready_o,
    output logic [DATA_W-1:0] out_data_o,
    output logic              out_fault_o,
    output logic              out_valid_o,
    input  logic              out_ready_i
);

    // Replicated stream into the pipe and product stream out of it
    tdmr_stream_if #(.DATA_W(DATA_W), .ID_W(ID_W)) rep_if ();
    tdmr_stream_if #(.DATA_W(DATA_W), .ID_W(ID_W)) prod_if ();

    time_dmr_start #(.DATA_W(DATA_W), .ID_W(ID_W)) u_start (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .enable_i   (enable_i),
        .in_data_i  (in_data_i),
        .in_valid_i (in_valid_i),
        .in_ready_o (in_ready_o),
        .rep        (rep_if.source)
    );

    mul_pipe #(.DATA_W(DATA_W), .ID_W(ID_W)) u_pipe (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .upset_i (upset_i),
        .rep     (rep_if.sink),
        .prod    (prod_if.source)
    );

    time_dmr_end #(.DATA_W(DATA_W), .ID_W(ID_W)) u_end (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .enable_i    (enable_i),
        .prod        (prod_if.sink),
        .out_data_o  (out_data_o),
        .out_fault_o (out_fault_o),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i)
    );

endmodule

// File: tdmr_props.sv
`timescale 1ns/10ps

module tdmr_props #(
    parameter int DATA_W = tdmr_pkg::DATA_W
) (
    input logic              clk_i,
    input logic              rst_n_i,
    input logic              in_valid_i,
    input logic              in_ready_o,
    input logic [DATA_W-1:0] out_data_o,
    input logic              out_fault_o,
    input logic              out_valid_o,
    input logic              out_ready_i
);

    // No result is offered while reset holds the design
    assert property (@(posedge clk_i) !rst_n_i |-> !out_valid_o)
        else $error("out_valid_o high during reset");

    // An offered result stays put until it is taken
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_valid_o && !out_ready_i |=>
            out_valid_o && $stable(out_data_o) && $stable(out_fault_o))
        else $error("Output changed while stalled");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        in_valid_i && !in_ready_o |=> in_valid_i)
        else $error("in_valid_i dropped before the word was accepted");

endmodule

bind tdmr_top tdmr_props #(.DATA_W(DATA_W)) u_props (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .out_data_o  (out_data_o),
    .out_fault_o (out_fault_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i)
);

// File: tb_tdmr.sv
`timescale 1ns/10ps

module tb_tdmr;

    import tdmr_pkg::*;

    // One table row with stimulus and the result it must give
    typedef struct packed {
        logic [OP_W-1:0]   a;
        logic [OP_W-1:0]   b;
        logic              en;
        logic              upset;
        logic              bp;
        logic [DATA_W-1:0] prod;
        logic              fault;
    } vec_t;

    typedef struct packed {
        logic [DATA_W-1:0] prod;
        logic              fault;
        logic              check_data;
    } exp_t;

    localparam int NUM_VEC     = 14;
    localparam int CYCLE_LIMIT = 20 * NUM_VEC;

    // a, b, enable, upset, back-pressure, product, fault
    vec_t vectors [NUM_VEC] = '{
        '{16'd3,     16'd5,     1'b1, 1'b0, 1'b0, 32'd15,         1'b0},
        '{16'd65535, 16'd65535, 1'b1, 1'b0, 1'b0, 32'd4294836225, 1'b0},
        '{16'd1234,  16'd10,    1'b1, 1'b0, 1'b0, 32'd12340,      1'b0},
        '{16'd0,     16'd777,   1'b0, 1'b0, 1'b0, 32'd0,          1'b0},
        '{16'd255,   16'd257,   1'b0, 1'b0, 1'b0, 32'd65535,      1'b0},
        '{16'd1000,  16'd1000,  1'b0, 1'b0, 1'b0, 32'd1000000,    1'b0},
        '{16'd65535, 16'd2,     1'b1, 1'b1, 1'b0, 32'd131070,     1'b1},
        '{16'd300,   16'd300,   1'b1, 1'b0, 1'b0, 32'd90000,      1'b0},
        '{16'd7,     16'd9,     1'b1, 1'b1, 1'b0, 32'd63,         1'b1},
        '{16'd40000, 16'd3,     1'b1, 1'b0, 1'b0, 32'd120000,     1'b0},
        '{16'd50000, 16'd50000, 1'b1, 1'b0, 1'b1, 32'd2500000000, 1'b0},
        '{16'd11,    16'd13,    1'b1, 1'b0, 1'b1, 32'd143,        1'b0},
        '{16'd20,    16'd30,    1'b1, 1'b0, 1'b1, 32'd600,        1'b0},
        '{16'd321,   16'd3,     1'b0, 1'b0, 1'b1, 32'd963,        1'b0}
    };

    logic              clk_i = 1'b0;
    logic              rst_n_i;
    logic              enable_i;
    logic              upset_i;
    logic [DATA_W-1:0] in_data_i;
    logic              in_valid_i;
    logic              in_ready_o;
    logic [DATA_W-1:0] out_data_o;
    logic              out_fault_o;
    logic              out_valid_o;
    logic              out_ready_i;

    exp_t expected_q [$];
    int   main_errors;
    int   mon_errors;
    int   n_out;
    int   cycles;
    logic bp_mode;

    tdmr_top #(.DATA_W(DATA_W), .ID_W(ID_W)) UUT (.*);

    always #10 clk_i = ~clk_i;

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp, inout int err_count);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
            err_count++;
        end
    endtask

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // Returns once every accepted word has left the design
    task automatic wait_idle();
        while (expected_q.size() != 0) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic apply_entry(input int idx);
        logic ready_seen;
        // Mode changes and upsets need an empty pipe
        if (vectors[idx].upset || (vectors[idx].en != enable_i)) begin
            wait_idle();
        end
        enable_i   = vectors[idx].en;
        bp_mode    = vectors[idx].bp;
        in_data_i  = {vectors[idx].a, vectors[idx].b};
        in_valid_i = 1'b1;
        upset_i    = vectors[idx].upset;
        ready_seen = 1'b0;
        while (!ready_seen) begin
            @(negedge clk_i);
            ready_seen = in_ready_o;
            @(posedge clk_i);
            #1;
        end
        expected_q.push_back({vectors[idx].prod, vectors[idx].fault, !vectors[idx].upset});
        in_valid_i = 1'b0;
        upset_i    = 1'b0;
    endtask

    initial begin : main_sequence
        rst_n_i     = 1'b0;
        enable_i    = 1'b0;
        upset_i     = 1'b0;
        in_data_i   = '0;
        in_valid_i  = 1'b0;
        bp_mode     = 1'b0;
        main_errors = 0;
        repeat (2) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        @(negedge clk_i);
        check_value("out_valid_o after reset", 32'(out_valid_o), 32'd0, main_errors);
        check_value("out_fault_o after reset", 32'(out_fault_o), 32'd0, main_errors);
        check_value("in_ready_o after reset", 32'(in_ready_o), 32'd1, main_errors);
        @(posedge clk_i);
        #1;
        for (int i = 0; i < NUM_VEC; i++) begin
            apply_entry(i);
        end
        wait_idle();
        // Quiet time in which an extra result would show up
        repeat (5) @(posedge clk_i);
        check_value("result count", 32'(n_out), 32'(NUM_VEC), main_errors);
        $display("Run complete: %0d results, %0d errors", n_out, main_errors + mon_errors);
        if (main_errors + mon_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin : ready_driver
        logic [31:0] lfsr;
        logic        bp_now;
        lfsr        = 32'hca861fae;
        out_ready_i = 1'b1;
        forever begin
            @(posedge clk_i);
            bp_now = bp_mode;
            #1;
            if (bp_now) begin
                out_ready_i = lfsr[0];
                lfsr        = lfsr_step(lfsr);
            end else begin
                out_ready_i = 1'b1;
            end
        end
    end

    // Outputs are sampled mid-cycle before the transfer on the next rising edge
    initial begin : output_monitor
        exp_t exp_item;
        mon_errors = 0;
        n_out      = 0;
        forever begin
            @(negedge clk_i);
            if (rst_n_i && out_valid_o && out_ready_i) begin
                if (expected_q.size() == 0) begin
                    $display("Result %0h at %0t arrived with no input pending", out_data_o, $time);
                    mon_errors++;
                end else begin
                    exp_item = expected_q.pop_front();
                    if (exp_item.check_data) begin
                        check_value("product", out_data_o, exp_item.prod, mon_errors);
                    end
                    check_value("fault", 32'(out_fault_o), 32'(exp_item.fault), mon_errors);
                end
                n_out++;
            end
        end
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("Timeout: run still busy after %0d cycles, %0d results seen", cycles, n_out);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: sources.f
+incdir+.
tdmr_pkg.sv
tdmr_stream_if.sv
time_dmr_start.sv
mul_pipe.sv
time_dmr_end.sv
tdmr_top.sv
tdmr_props.sv
tb_tdmr.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, then judge the run by its log
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert --top-module tb_tdmr -f sources.f > build.log 2>&1 &&
./obj_dir/Vtb_tdmr > sim.log 2>&1 ||
echo "Build or simulation stopped with an error, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -qs "^TESTS PASSED$" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
